// File: build.f
+incdir+hw
hw/ex_pkg.sv
hw/ex_if.sv
hw/ex_decode.sv
hw/ex_alu.sv
hw/ex_writeback.sv
hw/ex_stage.sv
dv/ex_stage_checker.sv
dv/ex_stage_tb.sv

// File: dv/ex_stage_checker.sv
// ==========================================================================
// Output rules of ex_stage, sampled at the rising clock edge. Bound into
// every ex_stage instance.
// ==========================================================================
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_checker (
    input logic             clk,
    input logic             rst_i,
    input logic             reg_we_i,
    input logic             jump_flag_i,
    input logic [`XLEN-1:0] jump_addr_i,
    input logic             mem_we_i,
    input logic             mem_req_i
);

    addr_needs_flag: assert property (@(posedge clk) disable iff (rst_i)
        !jump_flag_i |-> jump_addr_i == '0)
        else $error("jump address present without a taken jump");

    write_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        mem_we_i |-> mem_req_i)
        else $error("memory write enable without a memory request");

    // registers cleared by reset stay quiet one cycle on
    quiet_after_reset: assert property (@(posedge clk)
        rst_i |=> !reg_we_i && !jump_flag_i)
        else $error("register write or jump in the cycle after reset");

endmodule

bind ex_stage ex_stage_checker checker_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .reg_we_i    (reg_we_o),
    .jump_flag_i (jump_flag_o),
    .jump_addr_i (jump_addr_o),
    .mem_we_i    (mem_we_o),
    .mem_req_i   (mem_req_o)
);

// File: dv/ex_stage_tb.sv
// ==========================================================================
// Directed tests for ex_stage. Memory returns one word on any request, and
// reg1_rdata carries unrelated random data since the ALU works on op1.
// ==========================================================================
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_tb
    import ex_pkg::*;
;
    localparam int          MAX_CYCLES = 2000;   // tests need about 460
    localparam logic [31:0] NOP        = 32'h0000_0013;
    localparam logic [31:0] LOAD_WORD  = 32'h8F7E_C0A1;

    logic clk, rst_i, reg_we_i;
    inst_u inst_i;
    logic [`XLEN-1:0] inst_addr_i, op1_i, op2_i, op1_jump_i, op2_jump_i;
    logic [`XLEN-1:0] reg1_rdata_i, reg2_rdata_i, mem_rdata_i;
    logic [`REG_AW-1:0] reg_waddr_i, reg_waddr_o;
    logic [`XLEN-1:0] mem_raddr_o, mem_waddr_o, mem_wdata_o, reg_wdata_o;
    logic [`XLEN-1:0] jump_addr_o, inst_addr_o;
    logic mem_we_o, mem_req_o, reg_we_o, jump_flag_o;

    logic [`XLEN-1:0] mem_word, pc;
    int n_checks, n_errors, n_tests, cycle_count;

    // expected registered outputs of the instruction now in flight
    logic pend_valid, pend_we, pend_chk, pend_jf;
    logic [`XLEN-1:0] pend_wdata, pend_ja;
    logic [`REG_AW-1:0] pend_rd;

    ex_stage ex_stage_inst (.*);

    assign mem_rdata_i = mem_req_o ? mem_word : '0;   // memory stand-in

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [`REG_AW-1:0] got,
                              input logic [`REG_AW-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // RV32I result for an OP or OP-IMM instruction, b already sign extended
    function automatic logic [`XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            `F3_ADD:  alu_model = alt ? a - b : a + b;
            `F3_SLL:  alu_model = a << sh;
            `F3_SLT:  alu_model = {31'b0, $signed(a) < $signed(b)};
            `F3_SLTU: alu_model = {31'b0, a < b};
            `F3_XOR:  alu_model = a ^ b;
            `F3_SR:   alu_model = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            `F3_OR:   alu_model = a | b;
            default:  alu_model = a & b;
        endcase
    endfunction

    function automatic void expect_wb(input logic we, input logic chk,
                                      input logic [`XLEN-1:0] data,
                                      input logic [`REG_AW-1:0] rd, input logic jf,
                                      input logic [`XLEN-1:0] ja);
        pend_valid = 1'b1;
        pend_we    = we;
        pend_chk   = chk;
        pend_wdata = data;
        pend_rd    = rd;
        pend_jf    = jf;
        pend_ja    = ja;
    endfunction

    task automatic check_pending();
        if (pend_valid) begin
            check_bit("reg_we_o", reg_we_o, pend_we);
            check_addr("reg_waddr_o", reg_waddr_o, pend_rd);
            if (pend_chk) check_word("reg_wdata_o", reg_wdata_o, pend_wdata);
            check_bit("jump_flag_o", jump_flag_o, pend_jf);
            check_word("jump_addr_o", jump_addr_o, pend_ja);
        end
    endtask

    // drive one instruction, then look at the previous one's registered result
    task automatic issue(input logic [31:0] word, input logic [`XLEN-1:0] a, b, ja, jb, r2,
                         input logic we, input logic [`REG_AW-1:0] rd);
        @(posedge clk);
        inst_i       <= word;
        inst_addr_i  <= pc;
        op1_i        <= a;
        op2_i        <= b;
        op1_jump_i   <= ja;
        op2_jump_i   <= jb;
        reg1_rdata_i <= $urandom;
        reg2_rdata_i <= r2;
        reg_we_i     <= we;
        reg_waddr_i  <= rd;
        @(negedge clk);
        check_word("inst_addr_o", inst_addr_o, pc);
        pc = pc + 4;
        check_pending();
    endtask

    task automatic flush();
        issue(NOP, '0, '0, '0, '0, '0, 1'b0, '0);
        expect_wb(1'b0, 1'b1, '0, '0, 1'b0, '0);
    endtask

    task automatic report_test(input string name, input int err_start);
        n_tests++;
        $display("%-8s %s, %0d errors", name, (n_errors == err_start) ? "ok" : "FAILED",
                 n_errors - err_start);
    endtask

    task automatic test_reset();
        int err0;
        err0 = n_errors;
        check_bit("reg_we_o", reg_we_o, 1'b0);
        check_bit("jump_flag_o", jump_flag_o, 1'b0);
        check_word("reg_wdata_o", reg_wdata_o, '0);
        check_word("jump_addr_o", jump_addr_o, '0);
        check_addr("reg_waddr_o", reg_waddr_o, '0);
        report_test("reset", err0);
    endtask

    task automatic test_alu(input logic imm_form);
        int err0;
        logic [2:0] f3;
        logic alt, we;
        logic [11:0] imm;
        logic [`XLEN-1:0] a, b;
        logic [`REG_AW-1:0] rd;
        logic [31:0] word;
        err0 = n_errors;
        for (int k = 0; k < 16; k++) begin
            f3  = 3'(k);
            alt = k[3];
            if (alt && !(f3 == `F3_SR || (f3 == `F3_ADD && !imm_form))) continue;
            for (int n = 0; n < 20; n++) begin
                a  = $urandom;
                rd = 5'($urandom);
                we = ($urandom % 4) != 0;
                if (imm_form) begin
                    imm = 12'($urandom);
                    if (f3 == `F3_SLL || f3 == `F3_SR) imm = {alt ? `F7_ALT : 7'h00, imm[4:0]};
                    b    = {{20{imm[11]}}, imm};
                    word = {imm, 5'd1, f3, rd, `OP_I};
                end else begin
                    b    = $urandom;
                    word = {alt ? `F7_ALT : 7'h00, 5'd2, 5'd1, f3, rd, `OP_R};
                end
                issue(word, a, b, '0, '0, '0, we, rd);
                expect_wb(we, 1'b1, alu_model(f3, alt, a, b), rd, 1'b0, '0);
            end
        end
        flush();
        report_test(imm_form ? "alu_imm" : "alu_reg", err0);
    endtask

    task automatic test_branch();
        int err0;
        logic [2:0] f3;
        logic taken;
        logic [`XLEN-1:0] a, b, ja, jb;
        err0 = n_errors;
        for (int c = 0; c < 6; c++) begin
            f3 = 3'((c < 2) ? c : c + 2);
            for (int p = 0; p < 5; p++) begin
                case (p)
                    0: begin a = $urandom; b = a; end
                    1: begin a = 32'h0000_0003; b = 32'h0000_0009; end
                    2: begin a = 32'hFFFF_FFF0; b = 32'h0000_0010; end  // signed smaller only
                    3: begin a = 32'h7FFF_0000; b = 32'h8000_0000; end  // signed larger only
                    default: begin a = 32'h0000_0009; b = 32'h0000_0003; end
                endcase
                case (f3)
                    `F3_BEQ:  taken = (a == b);
                    `F3_BNE:  taken = (a != b);
                    `F3_BLT:  taken = $signed(a) < $signed(b);
                    `F3_BGE:  taken = $signed(a) >= $signed(b);
                    `F3_BLTU: taken = a < b;
                    default:  taken = a >= b;
                endcase
                ja = pc;
                jb = $urandom & 32'h0000_1FFE;
                issue({7'h00, 5'd2, 5'd1, f3, 5'd0, `OP_B}, a, b, ja, jb, '0, 1'b1, 5'd7);
                expect_wb(1'b0, 1'b0, '0, 5'd7, taken, taken ? ja + jb : '0);
            end
        end
        flush();
        report_test("branch", err0);
    endtask

    task automatic test_jump();
        int err0;
        logic [6:0] op;
        logic jump;
        logic [`XLEN-1:0] a, b, ja, jb, imm;
        logic [`REG_AW-1:0] rd;
        err0 = n_errors;
        for (int k = 0; k < 4; k++) begin
            rd  = 5'($urandom % 31 + 1);
            imm = $urandom & 32'hFFFF_F000;
            ja  = pc;
            jb  = $urandom & 32'h000F_FFFE;
            case (k)
                0: begin op = `OP_JAL; a = pc; b = 4; end
                1: begin op = `OP_JALR; a = pc; b = 4; ja = $urandom; end  // ja is rs1
                2: begin op = `OP_LUI; a = imm; b = '0; end
                default: begin op = `OP_AUIPC; a = pc; b = imm; end
            endcase
            jump = (k < 2);
            issue({imm[31:12], rd, op}, a, b, ja, jb, '0, 1'b1, rd);
            expect_wb(1'b1, 1'b1, a + b, rd, jump, jump ? ja + jb : '0);
        end
        flush();
        report_test("jump", err0);
    endtask

    task automatic test_load();
        int err0;
        logic [2:0] f3;
        logic [7:0] lb;
        logic [15:0] lh;
        logic [`XLEN-1:0] a, exp;
        logic [`REG_AW-1:0] rd;
        err0 = n_errors;
        mem_word <= LOAD_WORD;
        for (int k = 0; k < 5; k++) begin
            f3 = 3'((k < 3) ? k : k + 1);   // lb lh lw lbu lhu
            for (int off = 0; off < 4; off++) begin
                a  = $urandom & ~32'h3;
                rd = 5'($urandom);
                lb = 8'(LOAD_WORD >> (8 * off));
                lh = (off == 0) ? LOAD_WORD[15:0] : LOAD_WORD[31:16];
                case (f3)
                    `F3_LB:  exp = {{24{lb[7]}}, lb};
                    `F3_LH:  exp = {{16{lh[15]}}, lh};
                    `F3_LBU: exp = {24'h0, lb};
                    `F3_LHU: exp = {16'h0, lh};
                    default: exp = LOAD_WORD;
                endcase
                issue({12'(off), 5'd1, f3, rd, `OP_L}, a, 32'(off), '0, '0, '0, 1'b1, rd);
                check_bit("mem_req_o", mem_req_o, 1'b1);
                check_bit("mem_we_o", mem_we_o, 1'b0);
                check_word("mem_raddr_o", mem_raddr_o, a + 32'(off));
                expect_wb(1'b1, 1'b1, exp, rd, 1'b0, '0);
            end
        end
        flush();
        report_test("load", err0);
    endtask

    task automatic test_store();
        int err0;
        int sh;
        logic [2:0] f3;
        logic [`XLEN-1:0] a, r2, rword, mask, exp;
        err0 = n_errors;
        rword = $urandom;
        mem_word <= rword;
        for (int k = 0; k < 3; k++) begin
            f3 = 3'(k);   // sb sh sw
            for (int off = 0; off < 4; off++) begin
                a  = $urandom & ~32'h3;
                r2 = $urandom;
                sh = (f3 == `F3_SB) ? 8 * off : ((off == 0) ? 0 : 16);
                mask = ((f3 == `F3_SB) ? 32'h0000_00FF : 32'h0000_FFFF) << sh;
                exp = (f3 == `F3_SW) ? r2 : (rword & ~mask) | ((r2 << sh) & mask);
                issue({7'h00, 5'd2, 5'd1, f3, 5'(off), `OP_S}, a, 32'(off), '0, '0, r2,
                      1'b1, 5'd3);
                check_bit("mem_we_o", mem_we_o, 1'b1);
                check_bit("mem_req_o", mem_req_o, 1'b1);
                check_word("mem_waddr_o", mem_waddr_o, a + 32'(off));
                check_word("mem_wdata_o", mem_wdata_o, exp);
                expect_wb(1'b0, 1'b0, '0, 5'd3, 1'b0, '0);
            end
        end
        flush();
        report_test("store", err0);
    endtask

    initial begin
        void'($urandom(32'hb63a));
        rst_i        = 1'b1;
        inst_i       = NOP;
        inst_addr_i  = '0;
        op1_i        = '0;
        op2_i        = '0;
        op1_jump_i   = '0;
        op2_jump_i   = '0;
        reg1_rdata_i = '0;
        reg2_rdata_i = '0;
        reg_we_i     = 1'b0;
        reg_waddr_i  = '0;
        mem_word     = '0;
        pc           = 32'h0000_1000;
        pend_valid   = 1'b0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        test_reset();
        test_alu(1'b0);
        test_alu(1'b1);
        test_branch();
        test_jump();
        test_load();
        test_store();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: hw/ex_alu.sv
// ==========================================================================
// ALU, address sum and jump decision, all combinational. Shifts operate on
// op1; the amount is op2[4:0] or the shamt field.
// ==========================================================================
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_alu
    import ex_pkg::*;
(
    input  logic [`XLEN-1:0] op1_i,
    input  logic [`XLEN-1:0] op2_i,
    input  logic [`XLEN-1:0] op1_jump_i,
    input  logic [`XLEN-1:0] op2_jump_i,
    input  logic [`XLEN-1:0] reg1_rdata_i,
    input  logic [4:0]       shamt_i,
    ex_ctrl_if.sink          ctrl,
    ex_res_if.alu            res
);

    logic [`XLEN-1:0] sum;
    logic             lt_s;
    logic             lt_u;
    logic             eq;
    logic [4:0]       amt;
    logic [`XLEN-1:0] srl_val;
    logic [`XLEN-1:0] sr_mask;
    logic [`XLEN-1:0] sra_val;

    assign sum  = op1_i + op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;
    assign eq   = (op1_i == op2_i);

    assign amt     = ctrl.shift_imm ? shamt_i : op2_i[4:0];
    assign srl_val = op1_i >> amt;
    assign sr_mask = {`XLEN{1'b1}} >> amt;
    assign sra_val = (srl_val & sr_mask) | ({`XLEN{op1_i[`XLEN-1]}} & ~sr_mask);

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  res.alu_res = sum;
            ALU_SUB:  res.alu_res = op1_i - op2_i;
            ALU_SLL:  res.alu_res = op1_i << amt;
            ALU_SLT:  res.alu_res = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: res.alu_res = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  res.alu_res = op1_i ^ op2_i;
            ALU_SRL:  res.alu_res = srl_val;
            ALU_SRA:  res.alu_res = sra_val;
            ALU_OR:   res.alu_res = op1_i | op2_i;
            ALU_AND:  res.alu_res = op1_i & op2_i;
            default:  res.alu_res = sum;
        endcase
    end

    always_comb begin
        case (ctrl.cond)
            BR_ALWAYS: res.jump_taken = 1'b1;
            BR_EQ:     res.jump_taken = eq;
            BR_NE:     res.jump_taken = !eq;
            BR_LT:     res.jump_taken = lt_s;
            BR_GE:     res.jump_taken = !lt_s;
            BR_LTU:    res.jump_taken = lt_u;
            BR_GEU:    res.jump_taken = !lt_u;
            default:   res.jump_taken = 1'b0;
        endcase
    end

    assign res.sum         = sum;
    assign res.jump_target = op1_jump_i + op2_jump_i;

endmodule

// File: hw/ex_consts.svh
// ==========================================================================
// RV32I widths and encodings for the execute stage. Opcodes are the full
// 7-bit field; only the funct7 value that marks SUB and SRA is needed.
// ==========================================================================
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define XLEN        32
`define REG_AW      5

// major opcodes
`define OP_R        7'b0110011
`define OP_I        7'b0010011
`define OP_L        7'b0000011
`define OP_S        7'b0100011
`define OP_B        7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111

// alu funct3
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101     // srl / sra
`define F3_OR       3'b110
`define F3_AND      3'b111

// load and store funct3
`define F3_LB       3'b000
`define F3_LH       3'b001
`define F3_LW       3'b010
`define F3_LBU      3'b100
`define F3_LHU      3'b101
`define F3_SB       3'b000
`define F3_SH       3'b001
`define F3_SW       3'b010

// branch funct3
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define F7_ALT      7'b0100000 // sub, sra

`endif

// File: hw/ex_decode.sv
// ==========================================================================
// Instruction word to control fields. Unknown opcodes decode to no write,
// no memory access and no jump.
// ==========================================================================
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_decode
    import ex_pkg::*;
(
    input  inst_u   inst_i,
    input  logic    reg_we_i,
    ex_ctrl_if.dec  ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = inst_i.i.opcode;
    assign funct3 = inst_i.i.funct3;
    assign alt    = (inst_i.r.funct7 == `F7_ALT);

    // sub exists only in register form
    function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic sub_ok,
                                          input logic alt_bit);
        case (f3)
            `F3_ADD:  alu_op_of = (sub_ok && alt_bit) ? ALU_SUB : ALU_ADD;
            `F3_SLL:  alu_op_of = ALU_SLL;
            `F3_SLT:  alu_op_of = ALU_SLT;
            `F3_SLTU: alu_op_of = ALU_SLTU;
            `F3_XOR:  alu_op_of = ALU_XOR;
            `F3_SR:   alu_op_of = alt_bit ? ALU_SRA : ALU_SRL;
            `F3_OR:   alu_op_of = ALU_OR;
            `F3_AND:  alu_op_of = ALU_AND;
            default:  alu_op_of = ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.cond      = BR_NONE;
        ctrl.wb_sel    = WB_ALU;
        ctrl.mem_rd    = 1'b0;
        ctrl.mem_wr    = 1'b0;
        ctrl.mem_size  = SZ_WORD;
        ctrl.mem_uns   = 1'b0;
        ctrl.rd_we     = 1'b0;
        ctrl.shift_imm = 1'b0;
        case (opcode)
            `OP_R: begin
                ctrl.alu_op = alu_op_of(funct3, 1'b1, alt);
                ctrl.rd_we  = reg_we_i;
            end
            `OP_I: begin
                ctrl.alu_op    = alu_op_of(funct3, 1'b0, alt);
                ctrl.shift_imm = 1'b1;
                ctrl.rd_we     = reg_we_i;
            end
            `OP_L: begin
                ctrl.mem_rd = 1'b1;
                ctrl.wb_sel = WB_LOAD;
                ctrl.rd_we  = reg_we_i;
                case (funct3)
                    `F3_LB, `F3_LBU: ctrl.mem_size = SZ_BYTE;
                    `F3_LH, `F3_LHU: ctrl.mem_size = SZ_HALF;
                    default:         ctrl.mem_size = SZ_WORD; // lw
                endcase
                ctrl.mem_uns = (funct3 == `F3_LBU) || (funct3 == `F3_LHU);
            end
            `OP_S: begin
                ctrl.mem_wr = 1'b1;
                case (inst_i.s.funct3)
                    `F3_SB:  ctrl.mem_size = SZ_BYTE;
                    `F3_SH:  ctrl.mem_size = SZ_HALF;
                    default: ctrl.mem_size = SZ_WORD;
                endcase
            end
            `OP_B: begin
                case (funct3)
                    `F3_BEQ:  ctrl.cond = BR_EQ;
                    `F3_BNE:  ctrl.cond = BR_NE;
                    `F3_BLT:  ctrl.cond = BR_LT;
                    `F3_BGE:  ctrl.cond = BR_GE;
                    `F3_BLTU: ctrl.cond = BR_LTU;
                    `F3_BGEU: ctrl.cond = BR_GEU;
                    default:  ctrl.cond = BR_NONE;
                endcase
            end
            `OP_JAL, `OP_JALR: begin
                ctrl.cond   = BR_ALWAYS;
                ctrl.wb_sel = WB_LINK;   // pc + 4 arrives as op1 + op2
                ctrl.rd_we  = reg_we_i;
            end
            `OP_LUI, `OP_AUIPC: begin
                ctrl.rd_we = reg_we_i;   // plain add of op1 and op2
            end
            default: ;
        endcase
    end

endmodule

// File: hw/ex_if.sv
// ==========================================================================
// Control and result bundles inside the execute stage. No handshake,
// every field is a level valid for the cycle of the current instruction.
// ==========================================================================
`timescale 1ns/1ps
`include "ex_consts.svh"

interface ex_ctrl_if
    import ex_pkg::*;
;
    alu_op_e    alu_op;
    br_cond_e   cond;
    wb_sel_e    wb_sel;
    logic       mem_rd;
    logic       mem_wr;
    mem_size_e  mem_size;
    logic       mem_uns;    // zero extend on load
    logic       rd_we;
    logic       shift_imm;  // shift amount from the instruction field

    modport dec (
        output alu_op, cond, wb_sel, mem_rd, mem_wr, mem_size, mem_uns, rd_we,
        output shift_imm
    );
    modport sink (
        input alu_op, cond, wb_sel, mem_rd, mem_wr, mem_size, mem_uns, rd_we,
        input shift_imm
    );
endinterface

interface ex_res_if;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] sum;          // link value and memory address
    logic             jump_taken;
    logic [`XLEN-1:0] jump_target;

    modport alu (output alu_res, sum, jump_taken, jump_target);
    modport wb  (input alu_res, sum, jump_taken, jump_target);
endinterface

// File: hw/ex_pkg.sv
// ==========================================================================
// Types shared by the execute stage. The instruction word is one 32-bit
// value with R, I and S views over the same bits.
// ==========================================================================
`include "ex_consts.svh"

package ex_pkg;

    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]        imm;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0]         imm_hi;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [4:0]         imm_lo;
        logic [6:0]         opcode;
    } inst_s_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_ALWAYS, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    typedef enum logic [1:0] {SZ_BYTE, SZ_HALF, SZ_WORD} mem_size_e;

    typedef enum logic [1:0] {WB_ALU, WB_LINK, WB_LOAD} wb_sel_e;

endpackage

// File: hw/ex_stage.sv
// ==========================================================================
// RV32I execute stage, one instruction per clock with no stall input.
// Memory request in the same cycle, writeback and jump one cycle later.
// ==========================================================================
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic               clk,
    input  logic               rst_i,

    input  inst_u              inst_i,
    input  logic [`XLEN-1:0]   inst_addr_i,
    input  logic [`XLEN-1:0]   op1_i,
    input  logic [`XLEN-1:0]   op2_i,
    input  logic [`XLEN-1:0]   op1_jump_i,
    input  logic [`XLEN-1:0]   op2_jump_i,
    input  logic [`XLEN-1:0]   reg1_rdata_i,
    input  logic [`XLEN-1:0]   reg2_rdata_i,
    input  logic               reg_we_i,
    input  logic [`REG_AW-1:0] reg_waddr_i,
    input  logic [`XLEN-1:0]   mem_rdata_i,

    output logic [`XLEN-1:0]   mem_raddr_o,
    output logic [`XLEN-1:0]   mem_waddr_o,
    output logic [`XLEN-1:0]   mem_wdata_o,
    output logic               mem_we_o,
    output logic               mem_req_o,

    output logic [`XLEN-1:0]   reg_wdata_o,
    output logic               reg_we_o,
    output logic [`REG_AW-1:0] reg_waddr_o,
    output logic               jump_flag_o,
    output logic [`XLEN-1:0]   jump_addr_o,
    output logic [`XLEN-1:0]   inst_addr_o
);

    ex_ctrl_if ctrl_if ();
    ex_res_if  res_if ();

    assign inst_addr_o = inst_addr_i; // unregistered, same cycle

    ex_decode u_decode (
        .inst_i   (inst_i),
        .reg_we_i (reg_we_i),
        .ctrl     (ctrl_if.dec)
    );

    ex_alu u_alu (
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .op1_jump_i   (op1_jump_i),
        .op2_jump_i   (op2_jump_i),
        .reg1_rdata_i (reg1_rdata_i),
        .shamt_i      (inst_i.i.imm[4:0]),
        .ctrl         (ctrl_if.sink),
        .res          (res_if.alu)
    );

    ex_writeback u_writeback (
        .clk          (clk),
        .rst_i        (rst_i),
        .reg_waddr_i  (reg_waddr_i),
        .reg2_rdata_i (reg2_rdata_i),
        .mem_rdata_i  (mem_rdata_i),
        .ctrl         (ctrl_if.sink),
        .res          (res_if.wb),
        .mem_raddr_o  (mem_raddr_o),
        .mem_waddr_o  (mem_waddr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_we_o     (mem_we_o),
        .mem_req_o    (mem_req_o),
        .reg_wdata_o  (reg_wdata_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o)
    );

endmodule

// File: hw/ex_writeback.sv
// ==========================================================================
// Memory side is combinational in the instruction cycle. Register write and
// jump outputs are registered, one cycle after the instruction.
// ==========================================================================
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_writeback
    import ex_pkg::*;
(
    input  logic              clk,
    input  logic              rst_i,
    input  logic [`REG_AW-1:0] reg_waddr_i,
    input  logic [`XLEN-1:0]  reg2_rdata_i,
    input  logic [`XLEN-1:0]  mem_rdata_i,
    ex_ctrl_if.sink           ctrl,
    ex_res_if.wb              res,

    output logic [`XLEN-1:0]  mem_raddr_o,
    output logic [`XLEN-1:0]  mem_waddr_o,
    output logic [`XLEN-1:0]  mem_wdata_o,
    output logic              mem_we_o,
    output logic              mem_req_o,

    output logic [`XLEN-1:0]  reg_wdata_o,
    output logic              reg_we_o,
    output logic [`REG_AW-1:0] reg_waddr_o,
    output logic              jump_flag_o,
    output logic [`XLEN-1:0]  jump_addr_o
);

    logic [1:0]       lane;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;
    logic [`XLEN-1:0] ld_data;
    logic [`XLEN-1:0] st_data;
    logic [`XLEN-1:0] wdata;

    assign lane = res.sum[1:0];

    assign mem_req_o   = ctrl.mem_rd | ctrl.mem_wr;
    assign mem_we_o    = ctrl.mem_wr;
    assign mem_raddr_o = mem_req_o ? res.sum : '0; // stores read the word to merge
    assign mem_waddr_o = ctrl.mem_wr ? res.sum : '0;
    assign mem_wdata_o = ctrl.mem_wr ? st_data : '0;

    assign ld_byte = mem_rdata_i[lane*8 +: 8];
    assign ld_half = (lane == 2'b00) ? mem_rdata_i[15:0] : mem_rdata_i[31:16];

    always_comb begin
        case (ctrl.mem_size)
            SZ_BYTE: ld_data = {{24{ld_byte[7] & ~ctrl.mem_uns}}, ld_byte};
            SZ_HALF: ld_data = {{16{ld_half[15] & ~ctrl.mem_uns}}, ld_half};
            default: ld_data = mem_rdata_i;
        endcase
    end

    // replace the addressed lane of the read word
    always_comb begin
        st_data = mem_rdata_i;
        case (ctrl.mem_size)
            SZ_BYTE: st_data[lane*8 +: 8] = reg2_rdata_i[7:0];
            SZ_HALF: begin
                if (lane == 2'b00) begin
                    st_data[15:0] = reg2_rdata_i[15:0];
                end else begin
                    st_data[31:16] = reg2_rdata_i[15:0];
                end
            end
            default: st_data = reg2_rdata_i;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_LINK: wdata = res.sum;
            WB_LOAD: wdata = ld_data;
            default: wdata = res.alu_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_we_o    <= 1'b0;
            reg_wdata_o <= '0;
            reg_waddr_o <= '0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            reg_we_o    <= ctrl.rd_we;
            reg_wdata_o <= wdata;
            reg_waddr_o <= reg_waddr_i;
            jump_flag_o <= res.jump_taken;
            jump_addr_o <= res.jump_taken ? res.jump_target : '0;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build the ex_stage testbench with Verilator and run it once

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module ex_stage_tb \
        -f build.f -o ex_stage_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/ex_stage_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
